//--- verilog/biu_ahb_pkg.sv
// shared widths, bus codes and conversion helpers for the BIU to AHB-Lite subsystem
// data and address are fixed at 32 bits
// dword transfers have no legal hsize here and get rejected at the slave
package biu_ahb_pkg;

  localparam int XLEN        = 32;
  localparam int PLEN        = 32;
  localparam int NUM_PORTS   = 2;     // port 0 fetch, port 1 data
  localparam int PORT_W      = $clog2(NUM_PORTS);
  localparam int MEM_WORDS   = 1024;
  localparam int MEM_AW      = $clog2(MEM_WORDS);
  localparam int WAIT_STATES = 1;     // per beat, OKAY responses only

  typedef logic [PLEN-1:0]   addr_t;
  typedef logic [XLEN-1:0]   data_t;
  typedef logic [3:0]        burst_cnt_t;  // beats left minus one
  typedef logic [PORT_W-1:0] port_t;

  localparam addr_t ERR_BASE = 32'h8000_0000;  // bit 31 set means error

  ////////////////////////////////
  // BIU codes
  localparam logic [2:0] BIU_SINGLE = 3'd0;
  localparam logic [2:0] BIU_INCR   = 3'd1;
  localparam logic [2:0] BIU_WRAP4  = 3'd2;
  localparam logic [2:0] BIU_INCR4  = 3'd3;
  localparam logic [2:0] BIU_WRAP8  = 3'd4;
  localparam logic [2:0] BIU_INCR8  = 3'd5;
  localparam logic [2:0] BIU_WRAP16 = 3'd6;
  localparam logic [2:0] BIU_INCR16 = 3'd7;

  localparam logic [2:0] PROT_DATA       = 3'b001;  // clear for fetch
  localparam logic [2:0] PROT_PRIVILEGED = 3'b010;
  localparam logic [2:0] PROT_CACHEABLE  = 3'b100;

  ////////////////////////////////
  // AHB-Lite codes
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  localparam logic [2:0] HSIZE_BYTE  = 3'b000;
  localparam logic [2:0] HSIZE_HWORD = 3'b001;
  localparam logic [2:0] HSIZE_WORD  = 3'b010;

  localparam logic [2:0] HBURST_SINGLE = 3'b000;
  localparam logic [2:0] HBURST_INCR   = 3'b001;
  localparam logic [2:0] HBURST_WRAP4  = 3'b010;
  localparam logic [2:0] HBURST_INCR4  = 3'b011;
  localparam logic [2:0] HBURST_WRAP8  = 3'b100;
  localparam logic [2:0] HBURST_INCR8  = 3'b101;
  localparam logic [2:0] HBURST_WRAP16 = 3'b110;
  localparam logic [2:0] HBURST_INCR16 = 3'b111;

  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  localparam logic [3:0] HPROT_DATA       = 4'b0001;
  localparam logic [3:0] HPROT_PRIVILEGED = 4'b0010;
  localparam logic [3:0] HPROT_CACHEABLE  = 4'b1000;

  // slave response sequencing
  typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_ERR1, ST_ERR2} ahb_state_e;

  ////////////////////////////////
  // conversions
  function automatic burst_cnt_t biu_type2cnt(input logic [2:0] biu_type);
    case (biu_type)
      BIU_WRAP4, BIU_INCR4:   return 4'd3;
      BIU_WRAP8, BIU_INCR8:   return 4'd7;
      BIU_WRAP16, BIU_INCR16: return 4'd15;
      default:                return 4'd0;  // single and open incr
    endcase
  endfunction

  function automatic logic [2:0] biu_type2hburst(input logic [2:0] biu_type);
    case (biu_type)
      BIU_INCR:   return HBURST_INCR;
      BIU_WRAP4:  return HBURST_WRAP4;
      BIU_INCR4:  return HBURST_INCR4;
      BIU_WRAP8:  return HBURST_WRAP8;
      BIU_INCR8:  return HBURST_INCR8;
      BIU_WRAP16: return HBURST_WRAP16;
      BIU_INCR16: return HBURST_INCR16;
      BIU_SINGLE: return HBURST_SINGLE;
      default:    return HBURST_SINGLE;
    endcase
  endfunction

  function automatic logic [2:0] biu_size2hsize(input logic [2:0] biu_size);
    case (biu_size)
      3'd0:    return HSIZE_BYTE;
      3'd1:    return HSIZE_HWORD;
      3'd2:    return HSIZE_WORD;
      default: return 3'b011;  // dword and up are refused by the slave
    endcase
  endfunction

  function automatic logic [3:0] biu_prot2hprot(input logic [2:0] biu_prot);
    logic [3:0] hprot;
    hprot = 4'b0000;  // opcode, user, non-cacheable
    if (|(biu_prot & PROT_DATA))       hprot = hprot | HPROT_DATA;
    if (|(biu_prot & PROT_PRIVILEGED)) hprot = hprot | HPROT_PRIVILEGED;
    if (|(biu_prot & PROT_CACHEABLE))  hprot = hprot | HPROT_CACHEABLE;
    return hprot;
  endfunction

  // next word address of a burst, wrapping on the burst boundary
  function automatic addr_t nxt_addr(input addr_t addr, input logic [2:0] hburst);
    addr_t lin;
    lin = (addr + 32'd4) & ~32'd3;  // word aligned step
    case (hburst)
      HBURST_WRAP4:  return {addr[PLEN-1:4], lin[3:0]};
      HBURST_WRAP8:  return {addr[PLEN-1:5], lin[4:0]};
      HBURST_WRAP16: return {addr[PLEN-1:6], lin[5:0]};
      default:       return lin;
    endcase
  endfunction

endpackage

//--- verilog/biu2ahb.sv
`timescale 1ns/100ps
// BIU strobe/ack port to AHB-Lite master
// strobe fields must be held until biu_stb_ack_o and write data until biu_d_ack_o
// ack arrives after the data phase so latency depends on wait states and arbitration
// an ERROR ends the burst with one biu_err_o pulse and no ack for that beat
module biu2ahb
  import biu_ahb_pkg::*;
(
  input  logic       HCLK,
  input  logic       HRESETn,

  input  logic       biu_stb_i,
  output logic       biu_stb_ack_o,  // strobe taken, next one may follow
  output logic       biu_d_ack_o,    // write beat taken
  input  addr_t      biu_adri_i,
  output addr_t      biu_adro_o,     // address of the acked beat
  input  logic [2:0] biu_size_i,
  input  logic [2:0] biu_type_i,
  input  logic [2:0] biu_prot_i,
  input  logic       biu_lock_i,
  input  logic       biu_we_i,
  input  data_t      biu_d_i,
  output data_t      biu_q_o,
  output logic       biu_ack_o,
  output logic       biu_err_o,

  output logic [1:0] htrans_o,
  output addr_t      haddr_o,
  output logic       hwrite_o,
  output logic [2:0] hsize_o,
  output logic [2:0] hburst_o,
  output logic [3:0] hprot_o,
  output logic       hmastlock_o,
  output data_t      hwdata_o,
  input  logic       hready_i,
  input  logic       hresp_i,
  input  data_t      hrdata_i
);

  burst_cnt_t burst_cnt;   // beats still to issue after this one
  logic       data_ena;    // current address phase carries a beat
  logic       data_ena_d;  // current data phase carries a beat
  logic       burst_done;

  assign burst_done = (burst_cnt == '0);

  //////////////////////////////
  // BIU handshakes

  // no new strobe while the error pulse is out
  assign biu_stb_ack_o = hready_i & burst_done & biu_stb_i & ~biu_err_o;
  assign biu_d_ack_o   = hready_i & data_ena;
  // the second ERROR cycle also has hready high, keep it off ack
  assign biu_ack_o     = hready_i & data_ena_d & (hresp_i == HRESP_OKAY);
  assign biu_q_o       = hrdata_i;

  //////////////////////////////
  // address phase control

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      burst_cnt   <= '0;
      data_ena    <= 1'b0;
      data_ena_d  <= 1'b0;
      biu_err_o   <= 1'b0;
      htrans_o    <= HTRANS_IDLE;
      haddr_o     <= '0;
      hwrite_o    <= 1'b0;
      hsize_o     <= HSIZE_WORD;
      hburst_o    <= HBURST_SINGLE;
      hprot_o     <= HPROT_DATA | HPROT_PRIVILEGED;
      hmastlock_o <= 1'b0;
    end else begin
      biu_err_o <= 1'b0;  // single cycle pulse

      if (hready_i) begin
        data_ena_d <= data_ena;  // beat moves into data phase
        if (burst_done) begin
          if (biu_stb_ack_o) begin
            // new burst
            data_ena    <= 1'b1;
            burst_cnt   <= biu_type2cnt(biu_type_i);
            htrans_o    <= HTRANS_NONSEQ;
            haddr_o     <= biu_adri_i;
            hwrite_o    <= biu_we_i;
            hsize_o     <= biu_size2hsize(biu_size_i);
            hburst_o    <= biu_type2hburst(biu_type_i);
            hprot_o     <= biu_prot2hprot(biu_prot_i);
            hmastlock_o <= biu_lock_i;
          end else begin
            data_ena    <= 1'b0;
            htrans_o    <= HTRANS_IDLE;
            hmastlock_o <= biu_lock_i;
          end
        end else begin
          data_ena  <= 1'b1;
          burst_cnt <= burst_cnt - 4'd1;
          htrans_o  <= HTRANS_SEQ;
          haddr_o   <= nxt_addr(haddr_o, hburst_o);  // wraps per hburst
        end
      end else if (hresp_i == HRESP_ERROR) begin
        // first ERROR cycle, drop the rest of the burst
        burst_cnt <= '0;
        data_ena  <= 1'b0;
        htrans_o  <= HTRANS_IDLE;
        biu_err_o <= 1'b1;
      end
      // hready low without error holds everything
    end
  end

  //////////////////////////////
  // data phase payload

  always_ff @(posedge HCLK) begin
    if (biu_d_ack_o) hwdata_o <= biu_d_i;   // driven in the following data phase
    if (hready_i) biu_adro_o <= haddr_o;    // tracks the beat into its data phase
  end

  // a burst only continues out of an active beat
  a_no_seq_after_idle: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (htrans_o == HTRANS_IDLE) |=> (htrans_o != HTRANS_SEQ));

endmodule

//--- verilog/ahb_master_arb.sv
`timescale 1ns/100ps
// round-robin arbiter from several AHB-Lite masters onto one slave bus
// the grant moves only at an IDLE address phase with hready high so bursts stay whole
// a master waiting for the grant sees hready low and holds its address phase
module ahb_master_arb
  import biu_ahb_pkg::*;
(
  input  logic                       HCLK,
  input  logic                       HRESETn,

  input  logic  [NUM_PORTS-1:0][1:0] m_htrans_i,
  input  addr_t [NUM_PORTS-1:0]      m_haddr_i,
  input  logic  [NUM_PORTS-1:0]      m_hwrite_i,
  input  logic  [NUM_PORTS-1:0][2:0] m_hsize_i,
  input  data_t [NUM_PORTS-1:0]      m_hwdata_i,
  output logic  [NUM_PORTS-1:0]      m_hready_o,
  output logic  [NUM_PORTS-1:0]      m_hresp_o,
  output data_t [NUM_PORTS-1:0]      m_hrdata_o,

  output logic                       s_hsel_o,
  output addr_t                      s_haddr_o,
  output logic  [1:0]                s_htrans_o,
  output logic                       s_hwrite_o,
  output logic  [2:0]                s_hsize_o,
  output data_t                      s_hwdata_o,
  input  logic                       s_hreadyout_i,
  input  logic                       s_hresp_i,
  input  data_t                      s_hrdata_i
);

  port_t grant;      // address phase owner
  port_t owner;      // data phase owner
  port_t nxt_grant;

  // nearest requester after the current grantee wins
  always_comb begin
    port_t cand;
    nxt_grant = grant;
    for (int k = NUM_PORTS - 1; k > 0; k--) begin
      cand = port_t'((int'(grant) + k) % NUM_PORTS);
      if (m_htrans_i[cand] != HTRANS_IDLE) nxt_grant = cand;
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      grant <= '0;
      owner <= '0;
    end else if (s_hreadyout_i) begin
      owner <= grant;  // taken address phase becomes data phase
      if (m_htrans_i[grant] == HTRANS_IDLE) grant <= nxt_grant;
    end
  end

  //////////////////////////////
  // bus muxes

  assign s_haddr_o  = m_haddr_i[grant];
  assign s_htrans_o = m_htrans_i[grant];
  assign s_hwrite_o = m_hwrite_i[grant];
  assign s_hsize_o  = m_hsize_i[grant];
  assign s_hsel_o   = (s_htrans_o != HTRANS_IDLE);  // single slave
  assign s_hwdata_o = m_hwdata_i[owner];            // write data lags a phase

  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      // idle masters still need hready to finish a trailing data phase
      if (port_t'(i) == grant || m_htrans_i[i] == HTRANS_IDLE) begin
        m_hready_o[i] = s_hreadyout_i;
      end else begin
        m_hready_o[i] = 1'b0;
      end
      m_hresp_o[i]  = (port_t'(i) == owner) ? s_hresp_i : HRESP_OKAY;
      m_hrdata_o[i] = s_hrdata_i;  // qualified by each port's own ack
    end
  end

  // bursts are never split between masters
  a_grant_held_in_burst: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (m_htrans_i[grant] == HTRANS_SEQ) |=> $stable(grant));

endmodule

//--- verilog/ahb_sram_slave.sv
`timescale 1ns/100ps
// on-chip SRAM as an AHB-Lite slave
// every OKAY beat takes WAIT_STATES+1 data phase cycles
// addresses at or above ERR_BASE get the two-cycle ERROR response
// only MEM_WORDS words are decoded so higher addresses alias
module ahb_sram_slave
  import biu_ahb_pkg::*;
(
  input  logic       HCLK,
  input  logic       HRESETn,
  input  logic       hsel_i,
  input  addr_t      haddr_i,
  input  logic [1:0] htrans_i,
  input  logic       hwrite_i,
  input  logic [2:0] hsize_i,
  input  data_t      hwdata_i,
  output logic       hreadyout_o,
  output logic       hresp_o,
  output data_t      hrdata_o
);

  ahb_state_e        state;
  logic [3:0]        wait_cnt;  // wait cycles left in ST_WAIT
  logic              accept;
  logic              wr_en;
  addr_t             addr_q;    // registered address phase
  logic              write_q;
  logic [2:0]        size_q;
  logic [MEM_AW-1:0] idx;
  logic [3:0]        lanes;

  data_t mem [MEM_WORDS];

  // byte enables from size and low address bits
  function automatic logic [3:0] lane_mask(input logic [2:0] size, input logic [1:0] a);
    case (size)
      HSIZE_BYTE:  return 4'b0001 << a;
      HSIZE_HWORD: return 4'b0011 << {a[1], 1'b0};
      HSIZE_WORD:  return 4'b1111;
      default:     return 4'b0000;  // no write for unsupported sizes
    endcase
  endfunction

  assign hreadyout_o = (state == ST_IDLE) || (state == ST_ERR2) ||
                       (state == ST_WAIT && wait_cnt == '0);
  assign hresp_o     = (state == ST_ERR1 || state == ST_ERR2) ? HRESP_ERROR : HRESP_OKAY;
  assign accept      = hsel_i && hreadyout_o &&
                       (htrans_i == HTRANS_NONSEQ || htrans_i == HTRANS_SEQ);

  //////////////////////////////
  // response FSM

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state    <= ST_IDLE;
      wait_cnt <= '0;
    end else begin
      case (state)
        ST_ERR1: state <= ST_ERR2;
        ST_WAIT: if (wait_cnt != '0) wait_cnt <= wait_cnt - 4'd1;
        default: ;
      endcase
      if (hreadyout_o) begin  // data phase ends, next address phase sampled
        if (!accept) begin
          state <= ST_IDLE;
        end else if (haddr_i >= ERR_BASE) begin
          state <= ST_ERR1;
        end else begin
          state    <= ST_WAIT;
          wait_cnt <= 4'(WAIT_STATES);
        end
      end
    end
  end

  always_ff @(posedge HCLK) begin
    if (accept) begin
      addr_q  <= haddr_i;
      write_q <= hwrite_i;
      size_q  <= hsize_i;
    end
  end

  //////////////////////////////
  // storage

  assign idx      = addr_q[MEM_AW+1:2];
  assign lanes    = lane_mask(size_q, addr_q[1:0]);
  assign wr_en    = (state == ST_WAIT) && (wait_cnt == '0) && write_q;
  assign hrdata_o = mem[idx];  // whole word, master picks its lanes

  always_ff @(posedge HCLK) begin
    for (int b = 0; b < 4; b++) begin
      if (wr_en && lanes[b]) mem[idx][8*b +: 8] <= hwdata_i[8*b +: 8];
    end
  end

  // masters on this bus are 32-bit only
  a_size_max_word: assert property (@(posedge HCLK) disable iff (!HRESETn)
    accept |-> (hsize_i <= HSIZE_WORD));

endmodule

//--- verilog/biu_ahb_top.sv
`timescale 1ns/100ps
// BIU ports to one AHB-Lite bus ending in on-chip SRAM
// port 0 is instruction fetch and port 1 is data
// transfer latency varies with arbitration so use ack or err as the end of a beat
module biu_ahb_top
  import biu_ahb_pkg::*;
(
  input  logic                       HCLK,
  input  logic                       HRESETn,

  input  logic  [NUM_PORTS-1:0]      biu_stb_i,
  output logic  [NUM_PORTS-1:0]      biu_stb_ack_o,
  output logic  [NUM_PORTS-1:0]      biu_d_ack_o,
  input  addr_t [NUM_PORTS-1:0]      biu_adri_i,
  output addr_t [NUM_PORTS-1:0]      biu_adro_o,
  input  logic  [NUM_PORTS-1:0][2:0] biu_size_i,
  input  logic  [NUM_PORTS-1:0][2:0] biu_type_i,
  input  logic  [NUM_PORTS-1:0][2:0] biu_prot_i,
  input  logic  [NUM_PORTS-1:0]      biu_lock_i,
  input  logic  [NUM_PORTS-1:0]      biu_we_i,
  input  data_t [NUM_PORTS-1:0]      biu_d_i,
  output data_t [NUM_PORTS-1:0]      biu_q_o,
  output logic  [NUM_PORTS-1:0]      biu_ack_o,
  output logic  [NUM_PORTS-1:0]      biu_err_o
);

  // per-port master side
  logic  [NUM_PORTS-1:0][1:0] htrans;
  addr_t [NUM_PORTS-1:0]      haddr;
  logic  [NUM_PORTS-1:0]      hwrite;
  logic  [NUM_PORTS-1:0][2:0] hsize;
  data_t [NUM_PORTS-1:0]      hwdata;
  logic  [NUM_PORTS-1:0]      hready;
  logic  [NUM_PORTS-1:0]      hresp;
  data_t [NUM_PORTS-1:0]      hrdata;

  // shared slave bus
  logic       s_hsel;
  addr_t      s_haddr;
  logic [1:0] s_htrans;
  logic       s_hwrite;
  logic [2:0] s_hsize;
  data_t      s_hwdata;
  logic       s_hreadyout;
  logic       s_hresp;
  data_t      s_hrdata;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    biu2ahb u_biu2ahb (
      .HCLK          (HCLK),
      .HRESETn       (HRESETn),
      .biu_stb_i     (biu_stb_i[p]),
      .biu_stb_ack_o (biu_stb_ack_o[p]),
      .biu_d_ack_o   (biu_d_ack_o[p]),
      .biu_adri_i    (biu_adri_i[p]),
      .biu_adro_o    (biu_adro_o[p]),
      .biu_size_i    (biu_size_i[p]),
      .biu_type_i    (biu_type_i[p]),
      .biu_prot_i    (biu_prot_i[p]),
      .biu_lock_i    (biu_lock_i[p]),
      .biu_we_i      (biu_we_i[p]),
      .biu_d_i       (biu_d_i[p]),
      .biu_q_o       (biu_q_o[p]),
      .biu_ack_o     (biu_ack_o[p]),
      .biu_err_o     (biu_err_o[p]),
      .htrans_o      (htrans[p]),
      .haddr_o       (haddr[p]),
      .hwrite_o      (hwrite[p]),
      .hsize_o       (hsize[p]),
      .hburst_o      (),  // SRAM needs no burst, protection or lock info
      .hprot_o       (),
      .hmastlock_o   (),
      .hwdata_o      (hwdata[p]),
      .hready_i      (hready[p]),
      .hresp_i       (hresp[p]),
      .hrdata_i      (hrdata[p])
    );
  end

  ahb_master_arb u_arb (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .m_htrans_i    (htrans),
    .m_haddr_i     (haddr),
    .m_hwrite_i    (hwrite),
    .m_hsize_i     (hsize),
    .m_hwdata_i    (hwdata),
    .m_hready_o    (hready),
    .m_hresp_o     (hresp),
    .m_hrdata_o    (hrdata),
    .s_hsel_o      (s_hsel),
    .s_haddr_o     (s_haddr),
    .s_htrans_o    (s_htrans),
    .s_hwrite_o    (s_hwrite),
    .s_hsize_o     (s_hsize),
    .s_hwdata_o    (s_hwdata),
    .s_hreadyout_i (s_hreadyout),
    .s_hresp_i     (s_hresp),
    .s_hrdata_i    (s_hrdata)
  );

  ahb_sram_slave u_sram (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .hsel_i      (s_hsel),
    .haddr_i     (s_haddr),
    .htrans_i    (s_htrans),
    .hwrite_i    (s_hwrite),
    .hsize_i     (s_hsize),
    .hwdata_i    (s_hwdata),
    .hreadyout_o (s_hreadyout),
    .hresp_o     (s_hresp),
    .hrdata_o    (s_hrdata)
  );

endmodule

//--- dv/biu_ahb_tb.sv
`timescale 1ns/100ps
// testbench for biu_ahb_top with both BIU ports driven by tasks
// a byte-wide shadow of the SRAM predicts read data, only written words are read back
// port regions are disjoint so the shadow is updated when a write burst is queued
// shadow addresses alias into MEM_WORDS words like the slave decode
module biu_ahb_tb
  import biu_ahb_pkg::*;
();

  localparam int    XFER_BUDGET = 800;           // beats over the whole run, rounded up
  localparam int    RAND_BURSTS = 40;            // per port
  localparam int    RAND_WORDS  = 32;            // words in each random region
  localparam addr_t RAND_BASE   = 32'h0000_0800;
  localparam addr_t DIR_BASE    = 32'h0000_0400;

  logic HCLK;
  logic HRESETn;

  logic  [NUM_PORTS-1:0]      biu_stb_i;
  logic  [NUM_PORTS-1:0]      biu_stb_ack_o;
  logic  [NUM_PORTS-1:0]      biu_d_ack_o;
  addr_t [NUM_PORTS-1:0]      biu_adri_i;
  addr_t [NUM_PORTS-1:0]      biu_adro_o;
  logic  [NUM_PORTS-1:0][2:0] biu_size_i;
  logic  [NUM_PORTS-1:0][2:0] biu_type_i;
  logic  [NUM_PORTS-1:0][2:0] biu_prot_i;
  logic  [NUM_PORTS-1:0]      biu_lock_i;
  logic  [NUM_PORTS-1:0]      biu_we_i;
  data_t [NUM_PORTS-1:0]      biu_d_i;
  data_t [NUM_PORTS-1:0]      biu_q_o;
  logic  [NUM_PORTS-1:0]      biu_ack_o;
  logic  [NUM_PORTS-1:0]      biu_err_o;

  logic [7:0] shadow [MEM_WORDS*4];  // byte image of the SRAM

  // burst in flight per port
  addr_t exp_addr  [NUM_PORTS][16];
  data_t wdata     [NUM_PORTS][16];
  int    exp_beats [NUM_PORTS];
  logic  exp_we    [NUM_PORTS];
  logic  exp_err   [NUM_PORTS];
  int    ack_cnt   [NUM_PORTS];
  logic  err_seen  [NUM_PORTS];

  int val_errs;    // wrong data or address
  int resp_errs;   // wrong ack or err behavior
  int beat_total;

  always #10 HCLK = ~HCLK;  // 20 ns

  biu_ahb_top u_biu_ahb_top (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .biu_stb_i     (biu_stb_i),
    .biu_stb_ack_o (biu_stb_ack_o),
    .biu_d_ack_o   (biu_d_ack_o),
    .biu_adri_i    (biu_adri_i),
    .biu_adro_o    (biu_adro_o),
    .biu_size_i    (biu_size_i),
    .biu_type_i    (biu_type_i),
    .biu_prot_i    (biu_prot_i),
    .biu_lock_i    (biu_lock_i),
    .biu_we_i      (biu_we_i),
    .biu_d_i       (biu_d_i),
    .biu_q_o       (biu_q_o),
    .biu_ack_o     (biu_ack_o),
    .biu_err_o     (biu_err_o)
  );

  ////////////////////////////////
  // reference model

  // expected read word, whole word regardless of size
  function automatic data_t ref_read(input addr_t addr);
    int base;
    base = int'(addr[MEM_AW+1:2]) * 4;
    return {shadow[base+3], shadow[base+2], shadow[base+1], shadow[base]};
  endfunction

  // write data sits on the lanes of its address
  function automatic void apply_write(input addr_t addr, input logic [2:0] size,
                                      input data_t data);
    int base;
    int first;
    int nbytes;
    base = int'(addr[MEM_AW+1:2]) * 4;
    case (size)
      HSIZE_BYTE:  begin first = int'(addr[1:0]); nbytes = 1; end
      HSIZE_HWORD: begin first = int'(addr[1]) * 2; nbytes = 2; end
      default:     begin first = 0; nbytes = 4; end
    endcase
    for (int b = first; b < first + nbytes; b++) begin
      shadow[base + b] = data[8*b +: 8];
    end
  endfunction

  // wrap boundary of a BIU burst type
  function automatic logic [2:0] addr_mode(input logic [2:0] btype);
    case (btype)
      BIU_WRAP4:  return HBURST_WRAP4;
      BIU_WRAP8:  return HBURST_WRAP8;
      BIU_WRAP16: return HBURST_WRAP16;
      default:    return HBURST_INCR;   // linear
    endcase
  endfunction

  ////////////////////////////////
  // compare, sampled mid cycle

  always @(negedge HCLK) begin
    data_t exp_q;
    if (HRESETn) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (biu_ack_o[p]) begin
          beat_total++;
          if (exp_err[p] || ack_cnt[p] >= exp_beats[p]) begin
            $display("port %0d gave an acknowledge with no beat outstanding", p);
            resp_errs++;
          end else begin
            if (biu_adro_o[p] !== exp_addr[p][ack_cnt[p]]) begin
              $display("[FAIL] port %0d biu_adro_o got %h expected %h", p,
                       biu_adro_o[p], exp_addr[p][ack_cnt[p]]);
              val_errs++;
            end
            exp_q = ref_read(exp_addr[p][ack_cnt[p]]);
            if (!exp_we[p] && biu_q_o[p] !== exp_q) begin
              $display("[FAIL] port %0d biu_q_o got %h expected %h", p, biu_q_o[p], exp_q);
              val_errs++;
            end
          end
          ack_cnt[p]++;
        end
        if (biu_err_o[p]) begin
          if (!exp_err[p]) begin
            $display("port %0d reported an error outside the error window", p);
            resp_errs++;
          end
          err_seen[p] = 1'b1;
        end
      end
    end
  end

  ////////////////////////////////
  // port drivers

  task automatic run_burst(input int p, input addr_t addr, input logic [2:0] btype,
                           input logic [2:0] size, input logic we, input logic rand_data);
    int    beats;
    int    d_idx;
    logic  stb_done;
    logic  stb_hit;
    logic  dack_hit;
    addr_t a;
    beats = addr[31] ? 1 : int'(biu_type2cnt(btype)) + 1;  // error ends on beat one
    a     = addr;
    for (int k = 0; k < beats; k++) begin
      if (rand_data) wdata[p][k] = $urandom;
      exp_addr[p][k] = a;
      if (we && !addr[31]) apply_write(a, size, wdata[p][k]);
      a = nxt_addr(a, addr_mode(btype));
    end
    exp_beats[p] = beats;
    exp_we[p]    = we;
    exp_err[p]   = addr[31];
    ack_cnt[p]   = 0;
    err_seen[p]  = 1'b0;

    @(posedge HCLK);
    biu_stb_i[p]  <= 1'b1;
    biu_adri_i[p] <= addr;
    biu_size_i[p] <= size;        // BIU size codes equal hsize
    biu_type_i[p] <= btype;
    biu_we_i[p]   <= we;
    biu_prot_i[p] <= (p == 0) ? PROT_PRIVILEGED : (PROT_DATA | PROT_PRIVILEGED);
    biu_d_i[p]    <= wdata[p][0];
    stb_done = 1'b0;
    d_idx    = 0;
    do begin
      @(negedge HCLK);
      stb_hit  = biu_stb_ack_o[p];
      dack_hit = biu_d_ack_o[p];
      @(posedge HCLK);
      if (stb_hit) begin
        biu_stb_i[p] <= 1'b0;
        stb_done = 1'b1;
      end
      if (dack_hit && d_idx < beats - 1) begin
        d_idx++;
        biu_d_i[p] <= wdata[p][d_idx];  // next write beat
      end
    end while (!stb_done || (ack_cnt[p] < beats && !err_seen[p]));

    if (exp_err[p] && !err_seen[p]) begin
      $display("port %0d access to %h ended without the expected error", p, addr);
      resp_errs++;
    end
    exp_beats[p] = 0;  // later acks are stray
  endtask

  task automatic write_single(input int p, input addr_t addr, input logic [2:0] size,
                              input data_t data);
    wdata[p][0] = data;
    run_burst(p, addr, BIU_SINGLE, size, 1'b1, 1'b0);
  endtask

  task automatic read_single(input int p, input addr_t addr);
    run_burst(p, addr, BIU_SINGLE, HSIZE_WORD, 1'b0, 1'b0);
  endtask

  // no handshake activity while nothing is requested
  task automatic check_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge HCLK);
      if (biu_ack_o !== '0 || biu_err_o !== '0) begin
        $display("[FAIL] idle biu_ack_o %h biu_err_o %h expected 0", biu_ack_o, biu_err_o);
        val_errs++;
      end
      if (biu_stb_ack_o !== '0 || biu_d_ack_o !== '0) begin
        $display("[FAIL] idle biu_stb_ack_o %h biu_d_ack_o %h expected 0",
                 biu_stb_ack_o, biu_d_ack_o);
        val_errs++;
      end
    end
  endtask

  task automatic fill_region(input int p);
    addr_t base;
    base = RAND_BASE + addr_t'(p * 'h400);
    run_burst(p, base, BIU_INCR16, HSIZE_WORD, 1'b1, 1'b1);
    run_burst(p, base + 'h40, BIU_INCR16, HSIZE_WORD, 1'b1, 1'b1);
  endtask

  task automatic random_traffic(input int p);
    addr_t      base;
    addr_t      a;
    logic [2:0] btype;
    logic [2:0] size;
    int         woff;
    base = RAND_BASE + addr_t'(p * 'h400);
    for (int i = 0; i < RAND_BURSTS; i++) begin
      case ($urandom % 5)
        0:       btype = BIU_INCR4;
        1:       btype = BIU_WRAP4;
        2:       btype = BIU_WRAP8;
        3:       btype = BIU_INCR8;
        default: btype = BIU_SINGLE;
      endcase
      size = HSIZE_WORD;
      woff = int'($urandom % RAND_WORDS);
      if (btype == BIU_INCR4 && woff > RAND_WORDS - 4) woff = RAND_WORDS - 4;
      if (btype == BIU_INCR8 && woff > RAND_WORDS - 8) woff = RAND_WORDS - 8;
      a = base + addr_t'(woff * 4);
      if (btype == BIU_SINGLE) begin
        size = 3'($urandom % 3);
        if (size == HSIZE_BYTE) a = a + addr_t'($urandom % 4);
        else if (size == HSIZE_HWORD) a = a + addr_t'(2 * ($urandom % 2));
      end
      run_burst(p, a, btype, size, 1'($urandom % 2), 1'b1);
    end
  endtask

  ////////////////////////////////
  // main sequence

  initial begin
    addr_t db;
    void'($urandom(53));
    HCLK       = 1'b0;
    HRESETn    = 1'b0;
    biu_stb_i  = '0;
    biu_adri_i = '0;
    biu_size_i = '0;
    biu_type_i = '0;
    biu_prot_i = '0;
    biu_lock_i = '0;
    biu_we_i   = '0;
    biu_d_i    = '0;
    val_errs   = 0;
    resp_errs  = 0;
    beat_total = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      exp_beats[p] = 0;
      exp_we[p]    = 1'b0;
      exp_err[p]   = 1'b0;
      ack_cnt[p]   = 0;
      err_seen[p]  = 1'b0;
    end
    repeat (8) @(posedge HCLK);
    HRESETn <= 1'b1;

    check_quiet(12);

    for (int p = 0; p < NUM_PORTS; p++) begin
      db = DIR_BASE + addr_t'(p * 'h100);
      // single words
      write_single(p, db, HSIZE_WORD, 32'h1234_5678 ^ db);
      write_single(p, db + 4, HSIZE_WORD, 32'hCAFE_0000 | db);
      read_single(p, db);
      read_single(p, db + 4);
      // byte into lane 1, halfword into the upper half
      write_single(p, db + 1, HSIZE_BYTE, 32'h0000_A500);
      write_single(p, db + 6, HSIZE_HWORD, 32'h5A3C_0000);
      read_single(p, db);
      read_single(p, db + 4);
      // bursts, wrap reads cover the written blocks
      run_burst(p, db + 'h10, BIU_INCR4, HSIZE_WORD, 1'b1, 1'b1);
      run_burst(p, db + 'h18, BIU_WRAP4, HSIZE_WORD, 1'b0, 1'b0);
      run_burst(p, db + 'h34, BIU_WRAP8, HSIZE_WORD, 1'b1, 1'b1);
      run_burst(p, db + 'h28, BIU_WRAP8, HSIZE_WORD, 1'b0, 1'b0);
      run_burst(p, db + 'h20, BIU_INCR4, HSIZE_WORD, 1'b0, 1'b0);
      // error window then a normal access
      run_burst(p, ERR_BASE + 'h40, BIU_SINGLE, HSIZE_WORD, 1'b0, 1'b0);
      run_burst(p, ERR_BASE + 'h100, BIU_INCR4, HSIZE_WORD, 1'b1, 1'b1);
      read_single(p, db + 4);
    end

    // both ports at once in their own regions
    fork
      fill_region(0);
      fill_region(1);
    join
    fork
      random_traffic(0);
      random_traffic(1);
    join
    check_quiet(4);

    $display("beats %0d, value errors %0d, response errors %0d",
             beat_total, val_errs, resp_errs);
    if (val_errs + resp_errs == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // watchdog, 40 cycles per beat is far above the worst arbitration delay
  initial begin
    repeat (XFER_BUDGET * 40 + 500) @(posedge HCLK);
    $display("watchdog expired before the traffic finished");
    $display("beats %0d, value errors %0d, response errors %0d",
             beat_total, val_errs, resp_errs);
    $display("Errors found");
    $finish;
  end

endmodule

//--- build.f
verilog/biu_ahb_pkg.sv
verilog/biu2ahb.sv
verilog/ahb_master_arb.sv
verilog/ahb_sram_slave.sv
verilog/biu_ahb_top.sv
dv/biu_ahb_tb.sv

//--- Makefile
# Verilator build and run of the BIU to AHB-Lite subsystem testbench
# pass is decided by the pass line in the log, so a failing run returns an error

VERILATOR ?= verilator
TOP       ?= biu_ahb_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
